// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP ?= tb_execute_pipeline
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
PASS_MESSAGE = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MESSAGE)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+include
verilog/execute_pkg.sv
verilog/int_alu.sv
verilog/serial_divider.sv
verilog/operand_stage.sv
verilog/execute_stage.sv
verilog/execute_pipeline.sv
testbench/tb_execute_pipeline.sv

// File: include/execute_model.svh
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

// RISC-V divide rules, including divide by zero and signed overflow.
function automatic word_t model_divide(input div_op_t op, input word_t a, input word_t b);
  word_t result;
  logic overflow;
  overflow = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
  case (op)
    div_div: result = (b == '0) ? '1 : (overflow ? a : word_t'($signed(a) / $signed(b)));
    div_divu: result = (b == '0) ? '1 : a / b;
    div_rem: result = (b == '0) ? a : (overflow ? '0 : word_t'($signed(a) % $signed(b)));
    default: result = (b == '0) ? a : a % b;
  endcase
  return result;
endfunction

function automatic word_t model_result(input issue_t ins, input word_t regs [reg_count]);
  word_t a;
  word_t b;
  a = (ins.rs1 == '0) ? '0 : regs[ins.rs1];
  b = ins.use_imm ? ins.imm : ((ins.rs2 == '0) ? '0 : regs[ins.rs2]);
  if (ins.unit == unit_div) begin
    return model_divide(ins.div_op, a, (ins.rs2 == '0) ? '0 : regs[ins.rs2]);
  end
  case (ins.alu_op)
    alu_add: return a + b;
    alu_sub: return a - b;
    alu_and: return a & b;
    alu_or: return a | b;
    alu_xor: return a ^ b;
    alu_sll: return a << b[4:0];
    alu_srl: return a >> b[4:0];
    alu_sra: return word_t'($signed(a) >>> b[4:0]);
    alu_slt: return word_t'($signed(a) < $signed(b));
    alu_sltu: return word_t'(a < b);
    default: return ins.imm;
  endcase
endfunction

`endif

// File: testbench/tb_execute_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_execute_pipeline import execute_pkg::*; ();

  localparam int wait_limit = 100;

  typedef struct packed {
    reg_addr_t waddr;
    word_t wdata;
    logic timed;
    word_t cycle;
  } expect_t;

  logic clock = 1'b0;
  logic reset;
  logic clear;
  issue_t issue;
  logic stall;
  write_t writeback;

  int seed = 32'h406f5e22;
  int errors = 0;
  int checks = 0;
  word_t cycle = '0;
  logic div_pending = 1'b0;
  string test_name = "reset";
  word_t model_regs [reg_count];
  word_t snapshot [reg_count];
  expect_t expected_q [$];

  `include "execute_model.svh"

  execute_pipeline u_execute_pipeline (
    .clock(clock),
    .reset(reset),
    .issue(issue),
    .clear(clear),
    .stall(stall),
    .writeback(writeback)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + word_t'(1);
  end

  //////////////////////////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s (%s): expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic abort_run(input string reason);
    errors++;
    $display("%s", reason);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Simulation failed");
    $finish;
  endtask

  // Writeback is registered, so it is stable at the falling edge.
  always @(negedge clock) begin : compare
    expect_t e;
    if (reset && writeback.wren) begin
      if (writeback.waddr == '0) begin
        errors++;
        $display("A write to register x0 appeared on writeback in test %s", test_name);
      end
      if (expected_q.size() == 0) begin
        errors++;
        $display("Writeback to x%0d arrived with no write pending", writeback.waddr);
      end else begin
        e = expected_q.pop_front();
        check_value("waddr", word_t'(e.waddr), word_t'(writeback.waddr));
        check_value("wdata", e.wdata, writeback.wdata);
        if (e.timed) begin
          check_value("alu latency", e.cycle + word_t'(2), cycle);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic issue_t make_alu(input alu_op_t op, input int rd, input int rs1,
                                      input int rs2, input word_t imm, input logic use_imm);
    issue_t ins;
    ins = '0;
    ins.valid = 1'b1;
    ins.unit = unit_alu;
    ins.alu_op = op;
    ins.rd = reg_addr_t'(rd);
    ins.rs1 = reg_addr_t'(rs1);
    ins.rs2 = reg_addr_t'(rs2);
    ins.imm = imm;
    ins.use_imm = use_imm;
    return ins;
  endfunction

  function automatic issue_t make_div(input div_op_t op, input int rd, input int rs1,
                                      input int rs2);
    issue_t ins;
    ins = make_alu(alu_add, rd, rs1, rs2, '0, 1'b0);
    ins.unit = unit_div;
    ins.div_op = op;
    return ins;
  endfunction

  function automatic issue_t random_alu();
    return make_alu(alu_op_t'(pick(11)), 1 + pick(7), pick(8), pick(8),
                    word_t'($random(seed)), 1'(pick(2)));
  endfunction

  function automatic issue_t random_div();
    return make_div(div_op_t'(pick(4)), 1 + pick(7), pick(8), pick(8));
  endfunction

  // The model takes the instruction at the edge the DUT takes it.
  task automatic accept_instr(input issue_t ins);
    expect_t e;
    e.wdata = model_result(ins, model_regs);
    e.waddr = ins.rd;
    e.timed = (ins.unit == unit_alu);
    e.cycle = cycle;
    if (ins.rd != '0) begin
      model_regs[ins.rd] = e.wdata;
      expected_q.push_back(e);
    end
    div_pending = (ins.unit == unit_div);
  endtask

  task automatic check_div_stall();
    if (div_pending) begin
      check_value("stall during divide", 32'd1, word_t'(stall));
      div_pending = 1'b0;
    end
  endtask

  // Called just after a rising edge; returns at the edge that takes the instruction.
  task automatic send_instr(input issue_t ins);
    int waited;
    waited = 0;
    issue <= ins;
    @(negedge clock);
    check_div_stall();
    while (stall) begin
      waited++;
      if (waited > wait_limit) begin
        abort_run("Timeout: stall stayed high while an instruction was held");
      end
      @(negedge clock);
    end
    accept_instr(ins);
    @(posedge clock);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    issue <= '0;
    @(negedge clock);
    check_div_stall();
    while (stall || expected_q.size() != 0) begin
      waited++;
      if (waited > wait_limit) begin
        abort_run("Timeout: the pipeline did not deliver all pending writes");
      end
      @(negedge clock);
    end
    @(posedge clock);
  endtask

  initial begin
    issue <= '0;
    clear <= 1'b0;
    reset <= 1'b0;
    for (int k = 0; k < reg_count; k++) begin
      model_regs[k] = '0;
    end
    repeat (16) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    check_value("stall after reset", '0, word_t'(stall));
    check_value("wren after reset", '0, word_t'(writeback.wren));
    @(posedge clock);
    for (int k = 1; k < reg_count; k++) begin
      send_instr(make_alu(alu_add, k, k, 0, '0, 1'b0));
    end
    drain();

    test_name = "random alu";
    for (int k = 1; k < 8; k++) begin
      send_instr(make_alu(alu_add, k, 0, 0, word_t'($random(seed)), 1'b1));
    end
    for (int n = 0; n < 200; n++) begin
      send_instr(random_alu());
    end
    drain();

    // x1 holds the most negative value, x2 holds -1 and x3 holds zero.
    test_name = "divide";
    send_instr(make_alu(alu_lui, 1, 0, 0, 32'h8000_0000, 1'b1));
    send_instr(make_alu(alu_add, 2, 0, 0, 32'hffff_ffff, 1'b1));
    send_instr(make_alu(alu_add, 3, 0, 0, '0, 1'b1));
    for (int op = 0; op < 4; op++) begin
      send_instr(make_div(div_op_t'(op), 6, 1, 2));
      send_instr(make_div(div_op_t'(op), 7, 4, 3));
      send_instr(make_div(div_op_t'(op), 8, 5, 0));
    end
    for (int n = 0; n < 24; n++) begin
      send_instr(random_div());
    end
    drain();

    test_name = "mixed stream";
    for (int n = 0; n < 80; n++) begin
      if (pick(4) == 0) begin
        send_instr(random_div());
      end else begin
        send_instr(random_alu());
      end
    end
    drain();

    test_name = "x0 writes";
    send_instr(make_alu(alu_add, 0, 1, 2, '0, 1'b0));
    send_instr(make_div(div_div, 0, 1, 2));
    send_instr(make_alu(alu_or, 9, 0, 0, '0, 1'b0));
    send_instr(make_alu(alu_add, 10, 0, 0, 32'h55, 1'b1));
    drain();

    //////////////////////////////////////////////////////////////////////
    // Flush
    //////////////////////////////////////////////////////////////////////

    test_name = "clear during divide";
    send_instr(make_alu(alu_add, 10, 0, 0, 32'h1234, 1'b1));
    drain();
    snapshot = model_regs;
    send_instr(make_div(div_divu, 10, 1, 2));
    issue <= '0;
    div_pending = 1'b0;
    repeat (6) begin
      @(negedge clock);
      check_value("stall during divide", 32'd1, word_t'(stall));
    end
    // This add shares the cycle with clear and must be dropped.
    @(posedge clock);
    clear <= 1'b1;
    issue <= make_alu(alu_add, 11, 0, 0, 32'h77, 1'b1);
    @(posedge clock);
    clear <= 1'b0;
    issue <= '0;
    @(negedge clock);
    check_value("stall after clear", '0, word_t'(stall));
    model_regs = snapshot;
    expected_q.delete();
    repeat (40) @(posedge clock);
    send_instr(make_alu(alu_add, 12, 10, 0, '0, 1'b0));
    send_instr(make_alu(alu_add, 13, 11, 0, '0, 1'b0));
    send_instr(make_div(div_rem, 14, 1, 2));
    drain();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/execute_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module execute_pipeline import execute_pkg::*; (
  input logic clock,
  input logic reset,
  input issue_t issue,
  input logic clear,
  output logic stall,
  output write_t writeback
);

  operand_t operand;
  write_t forward;
  div_req_t div_req;
  div_rsp_t div_rsp;

  operand_stage u_operand_stage (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .issue(issue),
    .stall(stall),
    .forward(forward),
    .writeback(writeback),
    .operand(operand)
  );

  execute_stage u_execute_stage (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .operand(operand),
    .div_rsp(div_rsp),
    .div_req(div_req),
    .stall(stall),
    .forward(forward),
    .writeback(writeback)
  );

  serial_divider u_serial_divider (
    .clock(clock),
    .reset(reset),
    .div_req(div_req),
    .div_rsp(div_rsp)
  );

endmodule

`default_nettype wire

// File: verilog/execute_pkg.sv
`default_nettype none

package execute_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int xlen = 32;
  localparam int reg_count = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

  //////////////////////////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_lui
  } alu_op_t;

  typedef enum logic [1:0] {
    div_div,
    div_divu,
    div_rem,
    div_remu
  } div_op_t;

  typedef enum logic {
    unit_alu,
    unit_div
  } unit_t;

  //////////////////////////////////////////////////////////////////////
  // Stage records
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic valid;
    unit_t unit;
    alu_op_t alu_op;
    div_op_t div_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t imm;
    logic use_imm;
  } issue_t;

  typedef struct packed {
    logic valid;
    unit_t unit;
    alu_op_t alu_op;
    div_op_t div_op;
    reg_addr_t rd;
    word_t rdata1;
    word_t rdata2;
    word_t imm;
    logic use_imm;
  } operand_t;

  typedef struct packed {
    logic wren;
    reg_addr_t waddr;
    word_t wdata;
  } write_t;

  typedef struct packed {
    logic start;
    logic abort;
    div_op_t div_op;
    word_t dividend;
    word_t divisor;
  } div_req_t;

  typedef struct packed {
    logic ready;
    word_t result;
  } div_rsp_t;

endpackage

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import execute_pkg::*; (
  input logic clock,
  input logic reset,
  input logic clear,
  input operand_t operand,
  input div_rsp_t div_rsp,
  output div_req_t div_req,
  output logic stall,
  output write_t forward,
  output write_t writeback
);

  typedef struct packed {
    write_t wr;
    logic issued;
  } exec_reg_t;

  exec_reg_t r;
  exec_reg_t rin;
  exec_reg_t v;

  word_t alu_result;
  logic is_div;
  logic v_stall;

  int_alu u_int_alu (
    .alu_op(operand.alu_op),
    .rdata1(operand.rdata1),
    .rdata2(operand.rdata2),
    .imm(operand.imm),
    .use_imm(operand.use_imm),
    .result(alu_result)
  );

  //////////////////////////////////////////////////////////////////////
  // Next record
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    v = r;

    is_div = operand.valid && (operand.unit == unit_div);

    // Start fires once, on the first cycle the divide sits here.
    div_req.start = is_div && !r.issued && !clear;
    div_req.abort = clear;
    div_req.div_op = operand.div_op;
    div_req.dividend = operand.rdata1;
    div_req.divisor = operand.rdata2;

    v_stall = is_div && !div_rsp.ready;

    v.wr.waddr = operand.rd;
    v.wr.wdata = (operand.unit == unit_div) ? div_rsp.result : alu_result;
    v.wr.wren = operand.valid && !v_stall && (operand.rd != '0);

    if (div_req.start) begin
      v.issued = 1'b1;
    end
    if (div_rsp.ready) begin
      v.issued = 1'b0;
    end

    // A flush drops the record and lets the operand stage move on.
    if (clear) begin
      v.wr.wren = 1'b0;
      v.issued = 1'b0;
      v_stall = 1'b0;
    end

    rin = v;

    stall = v_stall;
    forward = v.wr;
    writeback = r.wr;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r <= '0;
    end else begin
      r <= rin;
    end
  end

endmodule

`default_nettype wire

// File: verilog/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu import execute_pkg::*; (
  input alu_op_t alu_op,
  input word_t rdata1,
  input word_t rdata2,
  input word_t imm,
  input logic use_imm,
  output word_t result
);

  word_t op2;
  logic [$clog2(xlen)-1:0] shamt;

  always_comb begin
    op2 = use_imm ? imm : rdata2;
    shamt = op2[$clog2(xlen)-1:0];

    case (alu_op)
      alu_add: result = rdata1 + op2;
      alu_sub: result = rdata1 - op2;
      alu_and: result = rdata1 & op2;
      alu_or: result = rdata1 | op2;
      alu_xor: result = rdata1 ^ op2;
      alu_sll: result = rdata1 << shamt;
      alu_srl: result = rdata1 >> shamt;
      alu_sra: result = word_t'($signed(rdata1) >>> shamt);
      alu_slt: result = word_t'($signed(rdata1) < $signed(op2));
      alu_sltu: result = word_t'(rdata1 < op2);
      // The immediate arrives already shifted into the upper bits.
      alu_lui: result = imm;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage import execute_pkg::*; (
  input logic clock,
  input logic reset,
  input logic clear,
  input issue_t issue,
  input logic stall,
  input write_t forward,
  input write_t writeback,
  output operand_t operand
);

  word_t regs [reg_count];
  operand_t r;
  operand_t next;

  // Newest value wins, so the execute result is checked last.
  function automatic word_t read_reg(
    input reg_addr_t addr,
    input word_t file_data,
    input write_t fwd,
    input write_t wb
  );
    word_t data;
    data = file_data;
    if (wb.wren && wb.waddr == addr) begin
      data = wb.wdata;
    end
    if (fwd.wren && fwd.waddr == addr) begin
      data = fwd.wdata;
    end
    if (addr == '0) begin
      data = '0;
    end
    return data;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (writeback.wren && writeback.waddr != '0) begin
      regs[writeback.waddr] <= writeback.wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand register
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    next.valid = issue.valid;
    next.unit = issue.unit;
    next.alu_op = issue.alu_op;
    next.div_op = issue.div_op;
    next.rd = issue.rd;
    next.rdata1 = read_reg(issue.rs1, regs[issue.rs1], forward, writeback);
    next.rdata2 = read_reg(issue.rs2, regs[issue.rs2], forward, writeback);
    next.imm = issue.imm;
    next.use_imm = issue.use_imm;
  end

  // The register holds while execute stalls, so the issuer holds too.
  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      r <= '0;
    end else if (!stall) begin
      r <= next;
    end
  end

  assign operand = r;

endmodule

`default_nettype wire

// File: verilog/serial_divider.sv
`timescale 1ns/1ps
`default_nettype none

module serial_divider import execute_pkg::*; (
  input logic clock,
  input logic reset,
  input div_req_t div_req,
  output div_rsp_t div_rsp
);

  typedef enum logic [1:0] {
    idle,
    run,
    done
  } state_t;

  typedef logic [$clog2(xlen)-1:0] step_t;

  state_t state;
  step_t count;

  div_op_t op_q;
  word_t rem_q;
  word_t quo_q;
  word_t divisor_q;
  logic q_neg;
  logic r_neg;

  logic signed_op;
  logic dividend_neg;
  logic divisor_neg;
  logic [xlen:0] shifted;
  logic [xlen:0] trial;
  word_t result_value;

  always_comb begin
    signed_op = (div_req.div_op == div_div) || (div_req.div_op == div_rem);
    dividend_neg = signed_op && div_req.dividend[xlen-1];
    divisor_neg = signed_op && div_req.divisor[xlen-1];

    // Bit xlen of the trial is the borrow of a restoring step.
    shifted = {rem_q, quo_q[xlen-1]};
    trial = shifted - {1'b0, divisor_q};

    if (op_q == div_div || op_q == div_divu) begin
      result_value = q_neg ? -quo_q : quo_q;
    end else begin
      result_value = r_neg ? -rem_q : rem_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= idle;
      count <= '0;
      div_rsp <= '0;
    end else begin
      div_rsp.ready <= 1'b0;
      if (div_req.abort) begin
        state <= idle;
      end else begin
        case (state)
          idle: begin
            if (div_req.start) begin
              state <= run;
              count <= '0;
            end
          end
          run: begin
            count <= count + 1'b1;
            if (count == step_t'(xlen - 1)) begin
              state <= done;
            end
          end
          done: begin
            div_rsp.ready <= 1'b1;
            div_rsp.result <= result_value;
            state <= idle;
          end
          default: state <= idle;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (state == idle && div_req.start) begin
      op_q <= div_req.div_op;
      rem_q <= '0;
      quo_q <= dividend_neg ? -div_req.dividend : div_req.dividend;
      divisor_q <= divisor_neg ? -div_req.divisor : div_req.divisor;
      // A zero divisor keeps the all-ones quotient unsigned.
      q_neg <= (dividend_neg ^ divisor_neg) && (div_req.divisor != '0);
      r_neg <= dividend_neg;
    end else if (state == run) begin
      if (!trial[xlen]) begin
        rem_q <= trial[xlen-1:0];
        quo_q <= {quo_q[xlen-2:0], 1'b1};
      end else begin
        rem_q <= shifted[xlen-1:0];
        quo_q <= {quo_q[xlen-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire
